/* filelist.f */
verilog/rsa_pkg.sv
verilog/mont_mult.sv
verilog/rsa_prep.sv
verilog/rsa_exp.sv
verilog/rsa_top.sv
tb/tb_rsa_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the rsa testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --timescale 1ns/1ns \
    --top-module tb_rsa_top \
    -f filelist.f \
    || { echo "build failed"; exit 1; }

# pass only when the testbench printed its pass line
out="$(./obj_dir/Vtb_rsa_top)"
echo "$out"
echo "$out" | grep -qx "NO ERRORS" && exit 0 || { echo "simulation failed"; exit 1; }

/* tb/tb_rsa_top.sv */
`timescale 1ns/1ns

module tb_rsa_top;

    logic                      i_clk;
    logic                      i_rst;
    logic                      i_req_valid;
    logic                      o_req_ready;
    rsa_pkg::rsa_req_t         i_req;
    logic                      o_res_valid;
    logic                      i_res_ready;
    logic [rsa_pkg::RSA_W-1:0] o_res;

    logic [31:0] lfsr_q;
    int          checks;
    int          errors;

    rsa_top dut (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_req_valid (i_req_valid),
        .o_req_ready (o_req_ready),
        .i_req       (i_req),
        .o_res_valid (o_res_valid),
        .i_res_ready (i_res_ready),
        .o_res       (o_res)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    // galois lfsr for x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (out) begin
            lfsr_q = lfsr_q ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic logic [rsa_pkg::RSA_W-1:0] rand_word();
        logic [rsa_pkg::RSA_W-1:0] w;
        for (int i = 0; i < rsa_pkg::RSA_W; i++) begin
            w[i] = lfsr_bit();
        end
        return w;
    endfunction

    // shift-add a*b mod n taking b from the msb
    function automatic logic [rsa_pkg::RSA_W-1:0] mod_mul(input logic [rsa_pkg::RSA_W-1:0] a,
            input logic [rsa_pkg::RSA_W-1:0] b, input logic [rsa_pkg::RSA_W-1:0] n);
        logic [rsa_pkg::RSA_W:0] r;
        r = '0;
        for (int i = rsa_pkg::RSA_W - 1; i >= 0; i--) begin
            r = r << 1;
            if (r >= {1'b0, n}) begin
                r = r - {1'b0, n};
            end
            if (b[i]) begin
                r = r + {1'b0, a};
                if (r >= {1'b0, n}) begin
                    r = r - {1'b0, n};
                end
            end
        end
        return r[rsa_pkg::RSA_W-1:0];
    endfunction

    // square-and-multiply from the lsb of d
    function automatic logic [rsa_pkg::RSA_W-1:0] mod_exp(input logic [rsa_pkg::RSA_W-1:0] a,
            input logic [rsa_pkg::RSA_W-1:0] d, input logic [rsa_pkg::RSA_W-1:0] n);
        logic [rsa_pkg::RSA_W-1:0] res;
        logic [rsa_pkg::RSA_W-1:0] base;
        res  = rsa_pkg::RSA_W'(1);
        base = a;
        for (int i = 0; i < rsa_pkg::RSA_W; i++) begin
            if (d[i]) begin
                res = mod_mul(res, base, n);
            end
            base = mod_mul(base, base, n);
        end
        return res;
    endfunction

    function automatic rsa_pkg::rsa_req_t make_req(input logic [rsa_pkg::RSA_W-1:0] a,
            input logic [rsa_pkg::RSA_W-1:0] d, input logic [rsa_pkg::RSA_W-1:0] n);
        rsa_pkg::rsa_req_t r;
        r.a = a;
        r.d = d;
        r.n = n;
        return r;
    endfunction

    function automatic rsa_pkg::rsa_req_t random_req();
        rsa_pkg::rsa_req_t r;
        r.n = rand_word();
        r.n[rsa_pkg::RSA_W-1] = 1'b1;   // full width
        r.n[0] = 1'b1;                  // odd modulus
        r.a = rand_word() % r.n;
        r.d = rand_word();
        return r;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $finish;
    endtask

    task automatic check_word(input string name, input logic [rsa_pkg::RSA_W-1:0] got,
            input logic [rsa_pkg::RSA_W-1:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1) else begin
            $display("at %0t ns: %s", $time, what);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        $display("test %s finished with %0d errors", name, errors - err_before);
    endtask

    task automatic offer_req(input rsa_pkg::rsa_req_t r);
        @(posedge i_clk);
        #1;
        i_req_valid = 1'b1;
        i_req       = r;
    endtask

    // ready is read mid-cycle and the transfer happens on the next edge
    task automatic wait_req_taken();
        int n;
        n = 0;
        while (!o_req_ready) begin
            @(posedge i_clk);
            #1;
            n++;
            if (n > 200000) begin
                abort_run("timeout: the request was never accepted");
            end
        end
        @(posedge i_clk);
        #1;
        i_req_valid = 1'b0;
    endtask

    task automatic wait_res_valid();
        int n;
        n = 0;
        while (!o_res_valid) begin
            @(posedge i_clk);
            #1;
            n++;
            if (n > 200000) begin
                abort_run("timeout: no result came out of the engine");
            end
        end
    endtask

    task automatic take_res(output logic [rsa_pkg::RSA_W-1:0] res);
        wait_res_valid();
        res = o_res;
        i_res_ready = 1'b1;
        @(posedge i_clk);
        #1;
        i_res_ready = 1'b0;
    endtask

    task automatic run_one(input rsa_pkg::rsa_req_t r, output logic [rsa_pkg::RSA_W-1:0] res);
        offer_req(r);
        wait_req_taken();
        take_res(res);
        check_word("o_res", res, mod_exp(r.a, r.d, r.n));
    endtask

    task automatic test_small();
        int                        e0;
        logic [rsa_pkg::RSA_W-1:0] res;
        e0 = errors;
        run_one(make_req(rsa_pkg::RSA_W'(4), rsa_pkg::RSA_W'(13), rsa_pkg::RSA_W'(497)), res);
        check_word("o_res", res, rsa_pkg::RSA_W'(445));
        run_one(make_req({8{32'h1234_5678}}, {8{32'h0f1e_2d3c}}, {8{32'hd5a3_91c7}}), res);
        end_test("small values", e0);
    endtask

    task automatic test_edge_exp();
        int                        e0;
        logic [rsa_pkg::RSA_W-1:0] a;
        logic [rsa_pkg::RSA_W-1:0] n;
        logic [rsa_pkg::RSA_W-1:0] res;
        e0 = errors;
        a  = {8{32'h0bad_cafe}};
        n  = {8{32'hd5a3_91c7}};
        run_one(make_req(a, '0, n), res);
        check_word("o_res", res, rsa_pkg::RSA_W'(1));
        run_one(make_req(a, rsa_pkg::RSA_W'(1), n), res);
        check_word("o_res", res, a);
        run_one(make_req(a, '1, n), res);
        end_test("edge exponents", e0);
    endtask

    task automatic test_back_to_back();
        int                        e0;
        rsa_pkg::rsa_req_t         ra;
        rsa_pkg::rsa_req_t         rb;
        logic [rsa_pkg::RSA_W-1:0] res_a;
        logic [rsa_pkg::RSA_W-1:0] res_b;
        e0 = errors;
        ra = random_req();
        rb = random_req();
        offer_req(ra);
        wait_req_taken();
        offer_req(rb);
        wait_req_taken();
        check_true(!o_res_valid, "first result came out before the second request was taken");
        take_res(res_a);
        take_res(res_b);
        check_word("o_res", res_a, mod_exp(ra.a, ra.d, ra.n));
        check_word("o_res", res_b, mod_exp(rb.a, rb.d, rb.n));
        end_test("back to back", e0);
    endtask

    task automatic test_backpressure();
        int                        e0;
        rsa_pkg::rsa_req_t         r[3];
        logic [rsa_pkg::RSA_W-1:0] held;
        logic [rsa_pkg::RSA_W-1:0] res[3];
        e0 = errors;
        for (int i = 0; i < 3; i++) begin
            r[i] = random_req();
        end
        offer_req(r[0]);
        wait_req_taken();
        offer_req(r[1]);
        wait_req_taken();
        offer_req(r[2]);                // waits while both stages are full
        wait_res_valid();
        held = o_res;
        for (int i = 0; i < 64; i++) begin
            @(posedge i_clk);
            #1;
            check_true(o_res_valid, "o_res_valid dropped while the result was held");
            check_word("o_res", o_res, held);
            check_true(!o_req_ready, "a request was taken while both stages were full");
        end
        take_res(res[0]);
        wait_req_taken();
        take_res(res[1]);
        take_res(res[2]);
        for (int i = 0; i < 3; i++) begin
            check_word("o_res", res[i], mod_exp(r[i].a, r[i].d, r[i].n));
        end
        end_test("back-pressure", e0);
    endtask

    task automatic test_reset();
        int                        e0;
        logic [rsa_pkg::RSA_W-1:0] res;
        e0 = errors;
        offer_req(random_req());
        wait_req_taken();
        wait_res_valid();               // first result held, not taken
        offer_req(random_req());
        wait_req_taken();
        repeat (100) @(posedge i_clk);  // second job still in pre-scaling
        #1;
        i_rst = 1'b1;
        repeat (3) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        check_true(!o_res_valid, "o_res_valid is high after reset");
        check_true(o_req_ready, "the engine does not take requests after reset");
        run_one(random_req(), res);
        end_test("reset mid-operation", e0);
    endtask

    task automatic test_random();
        int                        e0;
        logic [rsa_pkg::RSA_W-1:0] res;
        e0 = errors;
        for (int i = 0; i < 5; i++) begin
            run_one(random_req(), res);
        end
        end_test("random requests", e0);
    endtask

    initial begin
        lfsr_q      = 32'd94905;
        checks      = 0;
        errors      = 0;
        i_rst       = 1'b1;
        i_req_valid = 1'b0;
        i_req       = '0;
        i_res_ready = 1'b0;
        repeat (8) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        test_small();
        test_edge_exp();
        test_back_to_back();
        test_backpressure();
        test_reset();
        test_random();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* verilog/rsa_top.sv */
`timescale 1ns/1ns

module rsa_top (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic                      i_req_valid,
    output logic                      o_req_ready,
    input  rsa_pkg::rsa_req_t         i_req,
    output logic                      o_res_valid,
    input  logic                      i_res_ready,
    output logic [rsa_pkg::RSA_W-1:0] o_res
);

    // job channel between the two stages
    logic              job_valid;
    logic              job_ready;
    rsa_pkg::rsa_job_t job;

    // moves a into the Montgomery domain
    rsa_prep u_prep (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_req_valid (i_req_valid),
        .o_req_ready (o_req_ready),
        .i_req       (i_req),
        .o_job_valid (job_valid),
        .i_job_ready (job_ready),
        .o_job       (job)
    );

    // square-and-multiply over d, holds the result
    rsa_exp u_exp (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_job_valid (job_valid),
        .o_job_ready (job_ready),
        .i_job       (job),
        .o_res_valid (o_res_valid),
        .i_res_ready (i_res_ready),
        .o_res       (o_res)
    );

endmodule

/* verilog/rsa_exp.sv */
`timescale 1ns/1ns

module rsa_exp (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic                      i_job_valid,
    output logic                      o_job_ready,
    input  rsa_pkg::rsa_job_t         i_job,
    output logic                      o_res_valid,
    input  logic                      i_res_ready,
    output logic [rsa_pkg::RSA_W-1:0] o_res
);

    rsa_pkg::exp_state_e           state_q;
    logic [rsa_pkg::RSA_CNT_W-1:0] idx_q;       // current bit of d
    logic [rsa_pkg::RSA_W-1:0]     d_q;
    logic [rsa_pkg::RSA_W-1:0]     n_q;
    logic [rsa_pkg::RSA_W-1:0]     t_q;         // a^(2^i) in Montgomery form
    logic [rsa_pkg::RSA_W-1:0]     m_q;         // running result, normal form
    logic                          pend_sqr_q;
    logic                          pend_mul_q;
    logic                          job_fire;
    logic                          sqr_start;
    logic                          mul_start;
    logic                          sqr_done;
    logic                          mul_done;
    logic [rsa_pkg::RSA_W-1:0]     sqr_res;
    logic [rsa_pkg::RSA_W-1:0]     mul_res;
    logic                          sqr_left;
    logic                          mul_left;
    logic                          last_bit;

    assign o_job_ready = (state_q == rsa_pkg::EXP_IDLE);
    assign o_res_valid = (state_q == rsa_pkg::EXP_OUT);
    assign o_res       = m_q;
    assign job_fire    = i_job_valid && o_job_ready;

    // squaring always runs, multiply only for a set bit
    assign sqr_start = (state_q == rsa_pkg::EXP_STEP);
    assign mul_start = sqr_start && d_q[idx_q[rsa_pkg::RSA_CNT_W-2:0]];

    assign sqr_left = pend_sqr_q && !sqr_done;
    assign mul_left = pend_mul_q && !mul_done;
    assign last_bit = (idx_q == rsa_pkg::RSA_CNT_W'(rsa_pkg::RSA_W - 1));

    // m * t * R^-1 keeps m out of the Montgomery domain
    mont_mult u_mul (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_start  (mul_start),
        .i_a      (m_q),
        .i_b      (t_q),
        .i_n      (n_q),
        .o_done   (mul_done),
        .o_result (mul_res)
    );

    mont_mult u_sqr (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_start  (sqr_start),
        .i_a      (t_q),
        .i_b      (t_q),
        .i_n      (n_q),
        .o_done   (sqr_done),
        .o_result (sqr_res)
    );

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_q    <= rsa_pkg::EXP_IDLE;
            idx_q      <= '0;
            pend_sqr_q <= 1'b0;
            pend_mul_q <= 1'b0;
        end else begin
            case (state_q)
                rsa_pkg::EXP_IDLE: begin
                    if (job_fire) begin
                        idx_q   <= '0;
                        state_q <= rsa_pkg::EXP_STEP;
                    end
                end
                rsa_pkg::EXP_STEP: begin
                    pend_sqr_q <= 1'b1;
                    pend_mul_q <= mul_start;
                    state_q    <= rsa_pkg::EXP_WAIT;
                end
                rsa_pkg::EXP_WAIT: begin
                    if (sqr_done) begin
                        pend_sqr_q <= 1'b0;
                    end
                    if (mul_done) begin
                        pend_mul_q <= 1'b0;
                    end
                    if (!sqr_left && !mul_left) begin   // all started ones back
                        if (last_bit) begin
                            state_q <= rsa_pkg::EXP_OUT;
                        end else begin
                            idx_q   <= idx_q + 1'b1;
                            state_q <= rsa_pkg::EXP_STEP;
                        end
                    end
                end
                rsa_pkg::EXP_OUT: begin
                    if (i_res_ready) begin
                        state_q <= rsa_pkg::EXP_IDLE;
                    end
                end
                default: begin
                    state_q <= rsa_pkg::EXP_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (job_fire) begin
            d_q <= i_job.d;
            n_q <= i_job.n;
            t_q <= i_job.t;
            m_q <= {{(rsa_pkg::RSA_W-1){1'b0}}, 1'b1};
        end else if (state_q == rsa_pkg::EXP_WAIT) begin
            if (sqr_done) begin
                t_q <= sqr_res;
            end
            if (mul_done) begin
                m_q <= mul_res;     // both finish on the same edge
            end
        end
    end

    a_res_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        o_res_valid && !i_res_ready |=> o_res_valid && $stable(o_res))
        else $error("rsa_exp: result changed while stalled");

endmodule

/* verilog/rsa_prep.sv */
`timescale 1ns/1ns

module rsa_prep (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_req_valid,
    output logic              o_req_ready,
    input  rsa_pkg::rsa_req_t i_req,
    output logic              o_job_valid,
    input  logic              i_job_ready,
    output rsa_pkg::rsa_job_t o_job
);

    rsa_pkg::prep_state_e          state_q;
    logic [rsa_pkg::RSA_CNT_W-1:0] cnt_q;
    rsa_pkg::rsa_job_t             job_q;
    logic [rsa_pkg::RSA_W:0]       dbl;
    logic [rsa_pkg::RSA_W-1:0]     t_next;
    logic                          req_fire;

    assign o_req_ready = (state_q == rsa_pkg::PREP_IDLE);
    assign o_job_valid = (state_q == rsa_pkg::PREP_OUT);
    assign o_job       = job_q;
    assign req_fire    = i_req_valid && o_req_ready;

    // t < n, so 2t < 2n and one subtract is enough
    assign dbl    = {job_q.t, 1'b0};
    assign t_next = (dbl >= {1'b0, job_q.n}) ? dbl[rsa_pkg::RSA_W-1:0] - job_q.n
                                             : dbl[rsa_pkg::RSA_W-1:0];

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_q <= rsa_pkg::PREP_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                rsa_pkg::PREP_IDLE: begin
                    if (req_fire) begin
                        cnt_q   <= '0;
                        state_q <= rsa_pkg::PREP_SHIFT;
                    end
                end
                rsa_pkg::PREP_SHIFT: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == rsa_pkg::RSA_CNT_W'(rsa_pkg::RSA_W - 1)) begin
                        state_q <= rsa_pkg::PREP_OUT;
                    end
                end
                rsa_pkg::PREP_OUT: begin
                    if (i_job_ready) begin  // job taken by the exponent stage
                        state_q <= rsa_pkg::PREP_IDLE;
                    end
                end
                default: begin
                    state_q <= rsa_pkg::PREP_IDLE;
                end
            endcase
        end
    end

    // d and n ride along untouched
    always_ff @(posedge i_clk) begin
        if (req_fire) begin
            job_q.t <= i_req.a;
            job_q.d <= i_req.d;
            job_q.n <= i_req.n;
        end else if (state_q == rsa_pkg::PREP_SHIFT) begin
            job_q.t <= t_next;
        end
    end

    a_job_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        o_job_valid && !i_job_ready |=> o_job_valid && $stable(o_job))
        else $error("rsa_prep: job changed while stalled");

endmodule

/* verilog/mont_mult.sv */
`timescale 1ns/1ns

module mont_mult (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic                      i_start,
    input  logic [rsa_pkg::RSA_W-1:0] i_a,      // scanned from the lsb
    input  logic [rsa_pkg::RSA_W-1:0] i_b,
    input  logic [rsa_pkg::RSA_W-1:0] i_n,      // odd modulus
    output logic                      o_done,
    output logic [rsa_pkg::RSA_W-1:0] o_result
);

    rsa_pkg::mont_state_e          state_q;
    logic [rsa_pkg::RSA_CNT_W-1:0] cnt_q;
    logic [rsa_pkg::RSA_W:0]       acc_q;       // stays below 2n
    logic [rsa_pkg::RSA_W+1:0]     add_b;
    logic [rsa_pkg::RSA_W+1:0]     add_n;
    logic [rsa_pkg::RSA_W:0]       acc_half;
    logic [rsa_pkg::RSA_W:0]       acc_fix;
    logic                          fix_q;

    // one iteration: add b if the bit is set, make even with n, halve
    always_comb begin
        add_b = {1'b0, acc_q};
        if (i_a[cnt_q[rsa_pkg::RSA_CNT_W-2:0]]) begin
            add_b = add_b + {2'b00, i_b};
        end
        add_n = add_b;
        if (add_b[0]) begin
            add_n = add_b + {2'b00, i_n};
        end
        acc_half = add_n[rsa_pkg::RSA_W+1:1];   // exact, sum is even here
    end

    // final conditional subtract
    assign acc_fix = (acc_q >= {1'b0, i_n}) ? acc_q - {1'b0, i_n} : acc_q;

    assign o_result = acc_q[rsa_pkg::RSA_W-1:0];

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_q <= rsa_pkg::MONT_IDLE;
            cnt_q   <= '0;
            fix_q   <= 1'b0;
            o_done  <= 1'b0;
        end else begin
            fix_q  <= (state_q == rsa_pkg::MONT_FIX);
            o_done <= fix_q;    // done lands one edge after the subtract
            case (state_q)
                rsa_pkg::MONT_IDLE: begin
                    if (i_start) begin
                        cnt_q   <= '0;
                        state_q <= rsa_pkg::MONT_RUN;
                    end
                end
                rsa_pkg::MONT_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == rsa_pkg::RSA_CNT_W'(rsa_pkg::RSA_W - 1)) begin
                        state_q <= rsa_pkg::MONT_FIX;
                    end
                end
                rsa_pkg::MONT_FIX: begin
                    state_q <= rsa_pkg::MONT_IDLE;
                end
                default: begin
                    state_q <= rsa_pkg::MONT_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_q == rsa_pkg::MONT_IDLE && i_start) begin
            acc_q <= '0;
        end else if (state_q == rsa_pkg::MONT_RUN) begin
            acc_q <= acc_half;
        end else if (state_q == rsa_pkg::MONT_FIX) begin
            acc_q <= acc_fix;
        end
    end

    // the controller must wait for done before starting again
    a_no_start_busy: assert property (@(posedge i_clk) disable iff (i_rst)
        i_start |-> state_q == rsa_pkg::MONT_IDLE)
        else $error("mont_mult: start while busy");

endmodule

/* verilog/rsa_pkg.sv */
package rsa_pkg;

    // operand width, fixed for this engine
    localparam int RSA_W = 256;

    // iteration counters must be able to hold RSA_W itself
    localparam int RSA_CNT_W = $clog2(RSA_W) + 1;

    // request at the top-level input
    typedef struct packed {
        logic [RSA_W-1:0] a;    // ciphertext
        logic [RSA_W-1:0] d;    // exponent
        logic [RSA_W-1:0] n;    // modulus, odd
    } rsa_req_t;

    // job handed from pre-scaling to the exponent stage
    typedef struct packed {
        logic [RSA_W-1:0] t;    // a * 2^RSA_W mod n
        logic [RSA_W-1:0] d;
        logic [RSA_W-1:0] n;
    } rsa_job_t;

    typedef enum logic [1:0] {
        MONT_IDLE,
        MONT_RUN,
        MONT_FIX
    } mont_state_e;

    typedef enum logic [1:0] {
        PREP_IDLE,
        PREP_SHIFT,
        PREP_OUT
    } prep_state_e;

    typedef enum logic [1:0] {
        EXP_IDLE,
        EXP_STEP,
        EXP_WAIT,
        EXP_OUT
    } exp_state_e;

endpackage
